/* afu_pkg.sv */
`default_nettype none

package afu_pkg;

  // Host job command codes, odd parity sent alongside
  typedef enum logic [7:0] {
    RESET = 8'h80,
    START = 8'h90
  } job_cmd_t;

  typedef logic [63:0] job_addr_t;   // Effective address with a job command
  typedef logic [63:0] err_vec_t;    // Error vector reported on job_done
  typedef logic [23:0] mmio_addr_t;  // MMIO word address
  typedef logic [63:0] mmio_data_t;

  // Error bit positions in err_vec_t
  localparam int ERR_CMD_PAR       = 0;
  localparam int ERR_ADDR_PAR      = 1;
  localparam int ERR_MMIO_ADDR_PAR = 2;
  localparam int ERR_MMIO_DATA_PAR = 3;

  // Bit order of the two-bit mmio_err report
  localparam int MMIO_ERR_ADDR = 1;
  localparam int MMIO_ERR_DATA = 0;

  // Job controller states
  typedef enum logic [1:0] {
    IDLE,
    RESETTING,
    REPORT,
    RUNNING
  } job_state_t;

endpackage

`default_nettype wire

/* parity_check.sv */
`timescale 1ns/10ps
`default_nettype none

module parity_check #(
  parameter int BITS = 8
) (
  input  logic            clock,
  input  logic            rstn,
  input  logic            in_valid,
  input  logic [BITS-1:0] data,
  input  logic            par,
  output logic            chk_valid,
  output logic            chk_err
);

  logic            s1_valid;
  logic [BITS-1:0] s1_data;
  logic            s1_par;

  // Stage one captures the word and its parity bit
  always_ff @(posedge clock) begin
    if (in_valid) begin
      s1_data <= data;
      s1_par  <= par;
    end
  end

  // Stage two, odd parity means the XOR over word and bit is one
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_valid  <= 1'b0;
      chk_valid <= 1'b0;
      chk_err   <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      chk_valid <= s1_valid;
      chk_err   <= s1_valid & (~^{s1_data, s1_par}); // Even count of ones
    end
  end

endmodule

`default_nettype wire

/* job_control.sv */
`timescale 1ns/10ps
`default_nettype none

module job_control import afu_pkg::*; #(
  parameter int RESET_CYCLES = 4
) (
  input  logic       clock,
  input  logic       rstn,
  input  logic       job_valid,
  input  job_cmd_t   job_cmd,
  input  logic       job_cmd_par,
  input  job_addr_t  job_addr,
  input  logic       job_addr_par,
  input  logic       cmd_chk_valid,
  input  logic       cmd_chk_err,
  input  logic       addr_chk_valid,
  input  logic       addr_chk_err,
  input  logic       mmio_err_valid,
  input  logic [1:0] mmio_err,
  output logic       job_running,
  output logic       job_done,
  output err_vec_t   job_error,
  output logic       afu_reset,
  output logic       cmd_chk_in_valid,
  output logic [7:0] cmd_chk_data,
  output logic       cmd_chk_par,
  output logic       addr_chk_in_valid,
  output job_addr_t  addr_chk_data,
  output logic       addr_chk_par
);

  localparam int CNT_W = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;

  job_state_t       state;
  logic [CNT_W-1:0] hold_cnt;   // Remaining reset hold cycles
  err_vec_t         err_latch;
  err_vec_t         err_in;
  logic             is_reset;
  logic             is_start;

  // Command register, also the checker inputs
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_chk_in_valid  <= 1'b0;
      addr_chk_in_valid <= 1'b0;
    end else begin
      cmd_chk_in_valid  <= job_valid;
      addr_chk_in_valid <= job_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (job_valid) begin
      cmd_chk_data  <= job_cmd;
      cmd_chk_par   <= job_cmd_par;
      addr_chk_data <= job_addr;
      addr_chk_par  <= job_addr_par;
    end
  end

  // Decode from the registered command, parity result comes later
  assign is_reset = cmd_chk_in_valid && (cmd_chk_data == RESET);
  assign is_start = cmd_chk_in_valid && (cmd_chk_data == START);

  // Checker results at their error bit positions
  always_comb begin
    err_in                    = '0;
    err_in[ERR_CMD_PAR]       = cmd_chk_valid & cmd_chk_err;
    err_in[ERR_ADDR_PAR]      = addr_chk_valid & addr_chk_err;
    err_in[ERR_MMIO_ADDR_PAR] = mmio_err_valid & mmio_err[MMIO_ERR_ADDR];
    err_in[ERR_MMIO_DATA_PAR] = mmio_err_valid & mmio_err[MMIO_ERR_DATA];
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state       <= IDLE;
      hold_cnt    <= '0;
      job_running <= 1'b0;
      afu_reset   <= 1'b0;
      job_done    <= 1'b0;
      job_error   <= '0;
      err_latch   <= '0;
    end else begin
      job_done  <= 1'b0;
      job_error <= '0;                 // Only carries data with job_done
      err_latch <= err_latch | err_in;
      if (is_reset) begin
        // RESET wins in every state and restarts the hold
        state       <= RESETTING;
        hold_cnt    <= CNT_W'(RESET_CYCLES - 1);
        afu_reset   <= 1'b1;
        job_running <= 1'b0;
      end else begin
        case (state)
          IDLE: begin
            if (is_start) begin
              state       <= RUNNING;
              job_running <= 1'b1;
            end
          end
          RUNNING: begin
            if (|err_in) begin
              state <= REPORT;  // Error completion
            end
          end
          REPORT: begin
            job_done    <= 1'b1;
            job_error   <= err_latch | err_in;
            err_latch   <= '0;
            job_running <= 1'b0;
            state       <= IDLE;
          end
          RESETTING: begin
            if (hold_cnt == '0) begin
              afu_reset <= 1'b0;
              job_done  <= 1'b1;
              job_error <= err_latch | err_in;
              err_latch <= '0;
              state     <= IDLE;
            end else begin
              hold_cnt <= hold_cnt - 1'b1;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* mmio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mmio_regs import afu_pkg::*; #(
  parameter int REG_COUNT = 4
) (
  input  logic       clock,
  input  logic       rstn,
  input  logic       mmio_valid,
  input  logic       mmio_read,
  input  mmio_addr_t mmio_addr,
  input  logic       mmio_addr_par,
  input  mmio_data_t mmio_wdata,
  input  logic       mmio_wdata_par,
  input  logic       job_running,
  input  logic       addr_chk_valid,
  input  logic       addr_chk_err,
  input  logic       data_chk_valid,
  input  logic       data_chk_err,
  output logic       mmio_ack,
  output mmio_data_t mmio_rdata,
  output logic       mmio_rdata_par,
  output logic       mmio_err_valid,
  output logic [1:0] mmio_err,
  output logic       addr_chk_in_valid,
  output mmio_addr_t addr_chk_data,
  output logic       addr_chk_par,
  output logic       data_chk_in_valid,
  output mmio_data_t data_chk_data,
  output logic       data_chk_par
);

  logic       in_read;
  logic       s1_read;
  logic       s2_read;
  mmio_addr_t s1_addr;
  mmio_addr_t s2_addr;
  mmio_data_t s1_wdata;
  mmio_data_t s2_wdata;
  mmio_data_t scratch [REG_COUNT];
  mmio_data_t rd_word;
  logic       addr_bad;
  logic       data_bad;
  logic       wr_ok;

  // Access register feeding both checkers
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      addr_chk_in_valid <= 1'b0;
      data_chk_in_valid <= 1'b0;
    end else begin
      addr_chk_in_valid <= mmio_valid;
      data_chk_in_valid <= mmio_valid & ~mmio_read; // Write data only
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_valid) begin
      in_read       <= mmio_read;
      addr_chk_data <= mmio_addr;
      addr_chk_par  <= mmio_addr_par;
      data_chk_data <= mmio_wdata;
      data_chk_par  <= mmio_wdata_par;
    end
  end

  // Shadow the access while the checkers run
  always_ff @(posedge clock) begin
    s1_read  <= in_read;
    s1_addr  <= addr_chk_data;
    s1_wdata <= data_chk_data;
    s2_read  <= s1_read;
    s2_addr  <= s1_addr;
    s2_wdata <= s1_wdata;
  end

  // addr_chk_valid marks the access slot at commit
  assign addr_bad = addr_chk_valid & addr_chk_err;
  assign data_bad = data_chk_valid & data_chk_err;
  assign wr_ok    = addr_chk_valid & ~s2_read & ~addr_bad & ~data_bad;

  assign mmio_err_valid                = addr_chk_valid;
  assign mmio_err[MMIO_ERR_ADDR]       = addr_bad;
  assign mmio_err[MMIO_ERR_DATA]       = data_bad;

  // Read select, zero for bad address or out of range
  always_comb begin
    rd_word = '0;
    if (!addr_bad) begin
      if (s2_addr == '0) begin
        rd_word = mmio_data_t'(job_running); // Status word
      end
      for (int i = 0; i < REG_COUNT; i++) begin
        if (s2_addr == mmio_addr_t'(i + 1)) begin
          rd_word = scratch[i];
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        scratch[i] <= '0;
      end
    end else if (wr_ok) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        if (s2_addr == mmio_addr_t'(i + 1)) begin
          scratch[i] <= s2_wdata;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_ack <= 1'b0;
    end else begin
      mmio_ack <= addr_chk_valid;  // Bad accesses are acked too
    end
  end

  always_ff @(posedge clock) begin
    if (addr_chk_valid && s2_read) begin
      mmio_rdata     <= rd_word;
      mmio_rdata_par <= ~^rd_word; // Odd parity
    end
  end

endmodule

`default_nettype wire

/* afu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module afu_top import afu_pkg::*; #(
  parameter int RESET_CYCLES = 4,
  parameter int REG_COUNT    = 4
) (
  input  logic       clock,
  input  logic       rstn,
  input  logic       job_valid,
  input  job_cmd_t   job_cmd,
  input  logic       job_cmd_par,
  input  job_addr_t  job_addr,
  input  logic       job_addr_par,
  output logic       job_running,
  output logic       job_done,
  output err_vec_t   job_error,
  output logic       afu_reset,
  input  logic       mmio_valid,
  input  logic       mmio_read,
  input  mmio_addr_t mmio_addr,
  input  logic       mmio_addr_par,
  input  mmio_data_t mmio_wdata,
  input  logic       mmio_wdata_par,
  output logic       mmio_ack,
  output mmio_data_t mmio_rdata,
  output logic       mmio_rdata_par
);

  // Job command and address checker links
  logic       cmd_in_valid, cmd_par, cmd_valid, cmd_err;
  logic [7:0] cmd_data;
  logic       jaddr_in_valid, jaddr_par, jaddr_valid, jaddr_err;
  job_addr_t  jaddr_data;

  // MMIO address and write data checker links
  logic       maddr_in_valid, maddr_par, maddr_valid, maddr_err;
  mmio_addr_t maddr_data;
  logic       mdata_in_valid, mdata_par, mdata_valid, mdata_err;
  mmio_data_t mdata_data;

  logic       mmio_err_valid;
  logic [1:0] mmio_err;

  job_control #(
    .RESET_CYCLES (RESET_CYCLES)
  ) job_control_i (
    .clock, .rstn, .job_valid, .job_cmd, .job_cmd_par, .job_addr, .job_addr_par,
    .cmd_chk_valid     (cmd_valid),
    .cmd_chk_err       (cmd_err),
    .addr_chk_valid    (jaddr_valid),
    .addr_chk_err      (jaddr_err),
    .mmio_err_valid, .mmio_err,
    .job_running, .job_done, .job_error, .afu_reset,
    .cmd_chk_in_valid  (cmd_in_valid),
    .cmd_chk_data      (cmd_data),
    .cmd_chk_par       (cmd_par),
    .addr_chk_in_valid (jaddr_in_valid),
    .addr_chk_data     (jaddr_data),
    .addr_chk_par      (jaddr_par)
  );

  mmio_regs #(
    .REG_COUNT (REG_COUNT)
  ) mmio_regs_i (
    .clock, .rstn, .mmio_valid, .mmio_read, .mmio_addr, .mmio_addr_par,
    .mmio_wdata, .mmio_wdata_par, .job_running,
    .addr_chk_valid    (maddr_valid),
    .addr_chk_err      (maddr_err),
    .data_chk_valid    (mdata_valid),
    .data_chk_err      (mdata_err),
    .mmio_ack, .mmio_rdata, .mmio_rdata_par, .mmio_err_valid, .mmio_err,
    .addr_chk_in_valid (maddr_in_valid),
    .addr_chk_data     (maddr_data),
    .addr_chk_par      (maddr_par),
    .data_chk_in_valid (mdata_in_valid),
    .data_chk_data     (mdata_data),
    .data_chk_par      (mdata_par)
  );

  parity_check #(.BITS(8)) cmd_par_chk (
    .clock, .rstn, .in_valid(cmd_in_valid), .data(cmd_data), .par(cmd_par),
    .chk_valid(cmd_valid), .chk_err(cmd_err)
  );

  parity_check #(.BITS($bits(job_addr_t))) addr_par_chk (
    .clock, .rstn, .in_valid(jaddr_in_valid), .data(jaddr_data), .par(jaddr_par),
    .chk_valid(jaddr_valid), .chk_err(jaddr_err)
  );

  parity_check #(.BITS($bits(mmio_addr_t))) mmio_addr_par_chk (
    .clock, .rstn, .in_valid(maddr_in_valid), .data(maddr_data), .par(maddr_par),
    .chk_valid(maddr_valid), .chk_err(maddr_err)
  );

  parity_check #(.BITS($bits(mmio_data_t))) mmio_data_par_chk (
    .clock, .rstn, .in_valid(mdata_in_valid), .data(mdata_data), .par(mdata_par),
    .chk_valid(mdata_valid), .chk_err(mdata_err)
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  // Reset held low for four rising edges
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clock);
    #2 rstn = 1'b1;
  end

endmodule

`default_nettype wire

/* afu_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module afu_chk import afu_pkg::*; (
  input logic     clock,
  input logic     rstn,
  input logic     job_done,
  input err_vec_t job_error,
  input logic     job_running,
  input logic     afu_reset
);

  // Error vector only carries data alongside done
  error_only_with_done: assert property (
    @(posedge clock) disable iff (!rstn) !job_done |-> (job_error == '0)
  ) else $error("job_error is nonzero while job_done is low");

  done_one_cycle: assert property (
    @(posedge clock) disable iff (!rstn) job_done |=> !job_done
  ) else $error("job_done stayed high for more than one cycle");

  reset_not_running: assert property (
    @(posedge clock) disable iff (!rstn) !(afu_reset && job_running)
  ) else $error("afu_reset and job_running are high together");

endmodule

bind job_control afu_chk afu_chk_i (
  .clock       (clock),
  .rstn        (rstn),
  .job_done    (job_done),
  .job_error   (job_error),
  .job_running (job_running),
  .afu_reset   (afu_reset)
);

`default_nettype wire

/* tb_afu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_afu import afu_pkg::*; ();

  localparam int RESET_CYCLES = 4;
  localparam int REG_COUNT    = 4;
  localparam int N_MMIO       = 40;
  localparam int N_RUN_MMIO   = 20;
  localparam int N_ERR_ROUNDS = 8;
  localparam int N_BAD_WR     = 8;
  // Cycles per operation for the run limit
  localparam int RESET_LEN    = RESET_CYCLES + 3;
  localparam int MMIO_LEN     = 4;
  localparam int START_LEN    = 2;
  localparam int ERR_LEN      = START_LEN + 6;
  localparam int CYCLE_LIMIT  = 10 + 2 * RESET_LEN + START_LEN
                              + (N_MMIO + N_RUN_MMIO) * MMIO_LEN
                              + N_ERR_ROUNDS * ERR_LEN
                              + N_BAD_WR * (2 * MMIO_LEN + RESET_LEN) + 100;

  logic       clock;
  logic       rstn;
  logic       job_valid;
  job_cmd_t   job_cmd;
  logic       job_cmd_par;
  job_addr_t  job_addr;
  logic       job_addr_par;
  logic       job_running;
  logic       job_done;
  err_vec_t   job_error;
  logic       afu_reset;
  logic       mmio_valid;
  logic       mmio_read;
  mmio_addr_t mmio_addr;
  logic       mmio_addr_par;
  mmio_data_t mmio_wdata;
  logic       mmio_wdata_par;
  logic       mmio_ack;
  mmio_data_t mmio_rdata;
  logic       mmio_rdata_par;

  integer      seed;
  int          cycle_count = 0;
  logic [63:0] model_regs [REG_COUNT];  // Scratch register model
  logic        model_running;
  err_vec_t    exp_err;                 // Errors latched since last done

  tb_clock tb_clock_i (.clock(clock), .rstn(rstn));

  afu_top #(
    .RESET_CYCLES (RESET_CYCLES),
    .REG_COUNT    (REG_COUNT)
  ) afu_top_i (
    .clock, .rstn, .job_valid, .job_cmd, .job_cmd_par, .job_addr, .job_addr_par,
    .job_running, .job_done, .job_error, .afu_reset,
    .mmio_valid, .mmio_read, .mmio_addr, .mmio_addr_par, .mmio_wdata, .mmio_wdata_par,
    .mmio_ack, .mmio_rdata, .mmio_rdata_par
  );

  function automatic logic odd_parity_bit(input logic [63:0] v);
    return ~^v;  // Total count of ones becomes odd
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic logic [63:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic mmio_addr_t rand_mmio_addr();
    logic [63:0] w;
    w = rand_word();
    if (rand_below(8) == 0) begin
      return w[23:0];  // Mostly far out of range
    end
    return mmio_addr_t'(rand_below(REG_COUNT + 3));
  endfunction

  // Status at 0, scratch at 1..REG_COUNT, zero elsewhere
  function automatic logic [63:0] model_read(input int a);
    if (a == 0) begin
      return 64'(model_running);
    end
    if (a >= 1 && a <= REG_COUNT) begin
      return model_regs[a - 1];
    end
    return '0;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("ERR time %0t: %s, got %h, expected %h", $time, what, got, want);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Time %0t: %s", $time, why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic send_job(input logic [7:0] code, input logic bad_cmd, input logic bad_addr);
    job_addr_t addr;
    addr         = rand_word();
    job_valid    = 1'b1;
    job_cmd      = job_cmd_t'(code);
    job_cmd_par  = odd_parity_bit(64'(code)) ^ bad_cmd;
    job_addr     = addr;
    job_addr_par = odd_parity_bit(addr) ^ bad_addr;
    step();
    job_valid = 1'b0;  // One-cycle strobe
  endtask

  task automatic do_reset();
    send_job(RESET, 1'b0, 1'b0);
    for (int k = 1; k <= RESET_CYCLES; k++) begin
      step();
      check_eq(64'(afu_reset), 64'd1, "afu_reset during hold");
      check_eq(64'(job_done), 64'd0, "job_done during hold");
      check_eq(64'(job_running), 64'd0, "job_running during hold");
    end
    step();
    check_eq(64'(afu_reset), 64'd0, "afu_reset after hold");
    check_eq(64'(job_done), 64'd1, "job_done after RESET");
    check_eq(job_error, exp_err, "job_error on RESET done");
    exp_err       = '0;
    model_running = 1'b0;
    step();
    check_eq(64'(job_done), 64'd0, "job_done pulse length");
    check_eq(job_error, 64'd0, "job_error after done");
  endtask

  task automatic do_start();
    send_job(START, 1'b0, 1'b0);
    step();
    check_eq(64'(job_running), 64'd1, "job_running after START");
    model_running = 1'b1;
  endtask

  task automatic mmio_access(input logic rd, input mmio_addr_t addr,
                             input logic bad_addr, input logic bad_data);
    mmio_data_t wdata;
    mmio_data_t want;
    wdata          = rd ? '0 : rand_word();
    mmio_valid     = 1'b1;
    mmio_read      = rd;
    mmio_addr      = addr;
    mmio_addr_par  = odd_parity_bit(64'(addr)) ^ bad_addr;
    mmio_wdata     = wdata;
    mmio_wdata_par = odd_parity_bit(wdata) ^ bad_data;
    step();
    mmio_valid = 1'b0;
    repeat (2) begin
      step();
      check_eq(64'(mmio_ack), 64'd0, "mmio_ack before third cycle");
    end
    step();
    check_eq(64'(mmio_ack), 64'd1, "mmio_ack three cycles after access");
    if (rd) begin
      want = model_read(int'(addr));
      check_eq(mmio_rdata, want, "mmio_rdata");
      check_eq(64'(mmio_rdata_par), 64'(odd_parity_bit(want)), "mmio_rdata_par");
    end else if (bad_addr || bad_data) begin
      // Dropped write leaves its error in the latch
      if (bad_addr) exp_err[ERR_MMIO_ADDR_PAR] = 1'b1;
      if (bad_data) exp_err[ERR_MMIO_DATA_PAR] = 1'b1;
    end else if (int'(addr) >= 1 && int'(addr) <= REG_COUNT) begin
      model_regs[int'(addr) - 1] = wdata;
    end
  endtask

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    logic [7:0] code;
    int         choice;
    logic       rd;
    logic       seen;
    mmio_addr_t addr;
    seed           = 32'h26e2_bdef;
    job_valid      = 1'b0;
    job_cmd        = RESET;
    job_cmd_par    = 1'b0;
    job_addr       = '0;
    job_addr_par   = 1'b0;
    mmio_valid     = 1'b0;
    mmio_read      = 1'b0;
    mmio_addr      = '0;
    mmio_addr_par  = 1'b0;
    mmio_wdata     = '0;
    mmio_wdata_par = 1'b0;
    model_running  = 1'b0;
    exp_err        = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = '0;
    end

    wait (rstn === 1'b1);
    step();
    check_eq(64'(job_running), 64'd0, "job_running after reset");
    check_eq(64'(job_done), 64'd0, "job_done after reset");
    check_eq(64'(afu_reset), 64'd0, "afu_reset after reset");
    check_eq(64'(mmio_ack), 64'd0, "mmio_ack after reset");
    check_eq(64'(afu_top_i.mmio_err_valid), 64'd0, "mmio_err_valid after reset");

    do_reset();

    // Random MMIO traffic while idle
    for (int i = 0; i < N_MMIO; i++) begin
      rd   = (rand_below(2) == 1);
      addr = rand_mmio_addr();
      mmio_access(rd, addr, 1'b0, 1'b0);
    end

    // Running flag holds through MMIO traffic
    do_start();
    for (int i = 0; i < N_RUN_MMIO; i++) begin
      rd   = (rand_below(2) == 1);
      addr = rand_mmio_addr();
      mmio_access(rd, addr, 1'b0, 1'b0);
      check_eq(64'(job_running), 64'd1, "job_running during MMIO traffic");
    end
    do_reset();

    // Bad job parity while running gives an error completion
    for (int r = 0; r < N_ERR_ROUNDS; r++) begin
      do_start();
      choice = rand_below(3);
      code   = 8'(rand_below(256));
      if (code == RESET) code = START;
      send_job(code, choice != 1, choice != 0);
      if (choice != 1) exp_err[ERR_CMD_PAR] = 1'b1;
      if (choice != 0) exp_err[ERR_ADDR_PAR] = 1'b1;
      seen = 1'b0;
      for (int n = 0; n < 4 && !seen; n++) begin
        step();
        seen = job_done;
      end
      if (!seen) begin
        abort_run("no job_done within 4 cycles of a job command with bad parity");
      end else begin
        check_eq(job_error, exp_err, "job_error on error completion");
        check_eq(64'(job_running), 64'd0, "job_running after error completion");
        exp_err       = '0;
        model_running = 1'b0;
        step();
        check_eq(64'(job_done), 64'd0, "job_done pulse length");
      end
    end

    // Dropped MMIO writes while idle show up on the next RESET
    for (int w = 0; w < N_BAD_WR; w++) begin
      addr   = mmio_addr_t'(1 + rand_below(REG_COUNT));
      choice = rand_below(3);
      mmio_access(1'b0, addr, choice != 1, choice != 0);
      mmio_access(1'b1, addr, 1'b0, 1'b0);
      do_reset();
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
afu_pkg.sv
parity_check.sv
job_control.sv
mmio_regs.sv
afu_top.sv
tb_clock.sv
afu_chk.sv
tb_afu.sv

/* Makefile */
TOP = tb_afu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
